// File: source/sm83_isa_pkg.sv
package sm83_isa_pkg;

    localparam int WORD_W = 8;
    localparam int ADDR_W = 16;

    // Opcode word, patterns below use ? as a wildcard in casez
    typedef logic [WORD_W-1:0] opcode_t;

    localparam opcode_t OP_NOP       = 8'b0000_0000;
    localparam opcode_t OP_LD_RR_NN  = 8'b00??_0001;
    localparam opcode_t OP_INCDEC_RR = 8'b00??_?011;   // Bit 3 picks DEC
    localparam opcode_t OP_INCDEC_R  = 8'b00??_?10?;   // Bit 0 picks DEC
    localparam opcode_t OP_LD_R_N    = 8'b00??_?110;

    // Forms outside the core set, run as NOP
    localparam opcode_t OP_HALT      = 8'b0111_0110;
    localparam opcode_t OP_INCDEC_HL = 8'b0011_010?;
    localparam opcode_t OP_LD_HL_N   = 8'b0011_0110;

    localparam opcode_t OP_LD_HL_R   = 8'b0111_0???;
    localparam opcode_t OP_LD_R_HL   = 8'b01??_?110;
    localparam opcode_t OP_LD_R_R    = 8'b01??_????;

    localparam opcode_t OP_ALU_A_HL  = 8'b10??_?110;
    localparam opcode_t OP_ALU_A_R   = 8'b10??_????;
    localparam opcode_t OP_ALU_A_N   = 8'b11??_?110;

    localparam opcode_t OP_JP_NN     = 8'b1100_0011;

    // Taken straight from opcode bits 5..3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

endpackage

// File: source/sm83_ctrl_pkg.sv
package sm83_ctrl_pkg;

    localparam int STEP_W = 3;

    // 8-bit register index, B..L are contiguous so the r8 field maps by offset
    typedef enum logic [3:0] {
        NONE = 4'h0,
        Z    = 4'h1,
        W    = 4'h2,
        B    = 4'h3,
        C    = 4'h4,
        D    = 4'h5,
        E    = 4'h6,
        H    = 4'h7,
        L    = 4'h8,
        SPH  = 4'h9,
        SPL  = 4'hA,
        PCH  = 4'hB,
        PCL  = 4'hC,
        A    = 4'hD,
        MEM  = 4'hF
    } reg8_t;

    // Pair index, BC..SP follow the rr field plus one
    typedef enum logic [2:0] {
        WZ,
        BC,
        DE,
        HL,
        SP,
        PC
    } reg16_t;

    typedef enum logic {R_WB_DB, R_WB_ALU} s_r_wb_t;

    typedef enum logic [1:0] {RR_WB_NONE, RR_WB_IDU, RR_WB_WZ} s_rr_wb_t;

    typedef enum logic {ACC_A, ACC_DB} s_acc_t;

    typedef enum logic {ARG_DB, ARG_ONE} s_arg_t;

    typedef enum logic {IDU_INC, IDU_DEC} idu_mode_t;

endpackage

// File: source/sm83_ctrl_if.sv
`timescale 1ns/10ps

interface sm83_ctrl_if;
    sm83_ctrl_pkg::reg16_t    s_ab;            // Address pair
    logic                     ab_zero;         // Force address to zero
    sm83_ctrl_pkg::reg8_t     s_db;            // Data bus source
    sm83_ctrl_pkg::reg8_t     t_db;            // Data bus target
    sm83_ctrl_pkg::s_r_wb_t   s_r_wb;
    sm83_isa_pkg::alu_op_t    alu_op;
    logic                     alu_flags_only;  // CP keeps A
    sm83_ctrl_pkg::s_acc_t    s_acc;
    sm83_ctrl_pkg::s_arg_t    s_arg;
    sm83_ctrl_pkg::idu_mode_t idu;
    sm83_ctrl_pkg::s_rr_wb_t  s_rr_wb;
    sm83_ctrl_pkg::reg16_t    t_rr_wb;
    logic                     wr_pc;           // PC takes the IDU result

    modport dec (
        output s_ab, ab_zero, s_db, t_db, s_r_wb, alu_op, alu_flags_only,
        output s_acc, s_arg, idu, s_rr_wb, t_rr_wb, wr_pc
    );

    modport dp (
        input s_ab, ab_zero, s_db, t_db, s_r_wb, alu_op, alu_flags_only,
        input s_acc, s_arg, idu, s_rr_wb, t_rr_wb, wr_pc
    );
endinterface

// File: source/sm83_alu.sv
`timescale 1ns/10ps

module sm83_alu (
    input  sm83_isa_pkg::alu_op_t   op,
    input  logic [7:0]              acc,
    input  logic [7:0]              arg,
    input  logic                    c_in,
    output logic [7:0]              res,
    output logic                    flag_z,
    output logic                    flag_n,
    output logic                    flag_h,
    output logic                    flag_c
);

    logic       sub;
    logic       carry;
    logic [7:0] added;
    logic [4:0] lo;
    logic [4:0] hi;

    always_comb begin
        sub = op inside {sm83_isa_pkg::ALU_SUB, sm83_isa_pkg::ALU_SBC, sm83_isa_pkg::ALU_CP};
        added = sub ? ~arg : arg;   // Subtract as add of the complement
        case (op)
            sm83_isa_pkg::ALU_ADC, sm83_isa_pkg::ALU_SBC: carry = c_in;
            sm83_isa_pkg::ALU_SUB, sm83_isa_pkg::ALU_CP:  carry = 1'b1;
            default:                                      carry = 1'b0;
        endcase

        // Two nibble adders give the half carry for free
        lo = {1'b0, acc[3:0]} + {1'b0, added[3:0]} + {4'b0, carry};
        hi = {1'b0, acc[7:4]} + {1'b0, added[7:4]} + {4'b0, lo[4]};

        res = {hi[3:0], lo[3:0]};
        flag_n = sub;
        flag_h = lo[4];
        flag_c = hi[4];
        if (op inside {sm83_isa_pkg::ALU_AND, sm83_isa_pkg::ALU_XOR, sm83_isa_pkg::ALU_OR}) begin
            case (op)
                sm83_isa_pkg::ALU_AND: res = acc & arg;
                sm83_isa_pkg::ALU_XOR: res = acc ^ arg;
                default:               res = acc | arg;
            endcase
            flag_n = 1'b0;
            flag_h = 1'b0;
            flag_c = 1'b0;
        end
        flag_z = (res == 8'h00);
    end

endmodule

// File: source/sm83_sequencer.sv
`timescale 1ns/10ps

module sm83_sequencer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ce,
    input  logic                                done,
    input  logic [sm83_isa_pkg::WORD_W-1:0]     data_in_latched,
    output sm83_isa_pkg::opcode_t               ir,
    output logic [sm83_ctrl_pkg::STEP_W-1:0]    step
);

    // The last step of each instruction fetches the next opcode
    always_ff @(posedge clk) begin
        if (!rst) begin
            ir <= sm83_isa_pkg::OP_NOP;   // First fetch runs as the tail of a NOP
            step <= '0;
        end else if (ce) begin
            if (done) begin
                ir <= data_in_latched;
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

// File: source/sm83_decoder.sv
`timescale 1ns/10ps

module sm83_decoder (
    input  sm83_isa_pkg::opcode_t               ir,
    input  logic [sm83_ctrl_pkg::STEP_W-1:0]    step,
    output logic                                done,
    sm83_ctrl_if.dec                            ctrl
);

    sm83_ctrl_pkg::reg8_t  r_dst;
    sm83_ctrl_pkg::reg8_t  r_src;
    sm83_ctrl_pkg::reg16_t rr;

    function automatic sm83_ctrl_pkg::reg8_t r8_of(input logic [2:0] f);
        if (f == 3'd7)
            return sm83_ctrl_pkg::A;
        if (f == 3'd6)
            return sm83_ctrl_pkg::MEM;   // (HL) forms are matched before use
        return sm83_ctrl_pkg::reg8_t'({1'b0, f} + 4'd3);
    endfunction

    assign r_dst = r8_of(ir[5:3]);
    assign r_src = r8_of(ir[2:0]);
    assign rr = sm83_ctrl_pkg::reg16_t'({1'b0, ir[5:4]} + 3'd1);

    always_comb begin
        done = 1'b0;
        ctrl.s_ab = sm83_ctrl_pkg::PC;
        ctrl.ab_zero = 1'b0;
        ctrl.s_db = sm83_ctrl_pkg::NONE;
        ctrl.t_db = sm83_ctrl_pkg::NONE;
        ctrl.s_r_wb = sm83_ctrl_pkg::R_WB_DB;
        ctrl.alu_op = sm83_isa_pkg::alu_op_t'(ir[5:3]);
        ctrl.s_acc = sm83_ctrl_pkg::ACC_A;
        ctrl.s_arg = sm83_ctrl_pkg::ARG_DB;
        ctrl.idu = sm83_ctrl_pkg::IDU_INC;
        ctrl.s_rr_wb = sm83_ctrl_pkg::RR_WB_NONE;
        ctrl.t_rr_wb = sm83_ctrl_pkg::WZ;
        ctrl.wr_pc = 1'b0;

        // First match wins, so the narrow patterns come first
        casez ({ir, step})
            {sm83_isa_pkg::OP_HALT, 3'd0},
            {sm83_isa_pkg::OP_INCDEC_HL, 3'd0},
            {sm83_isa_pkg::OP_LD_HL_N, 3'd0}:
                done = 1'b1;

            // Z <- [PC], PC++
            {sm83_isa_pkg::OP_LD_RR_NN, 3'd0},
            {sm83_isa_pkg::OP_LD_R_N, 3'd0},
            {sm83_isa_pkg::OP_ALU_A_N, 3'd0},
            {sm83_isa_pkg::OP_JP_NN, 3'd0}: begin
                ctrl.s_db = sm83_ctrl_pkg::MEM;
                ctrl.t_db = sm83_ctrl_pkg::Z;
                ctrl.wr_pc = 1'b1;
            end

            // W <- [PC], PC++
            {sm83_isa_pkg::OP_LD_RR_NN, 3'd1},
            {sm83_isa_pkg::OP_JP_NN, 3'd1}: begin
                ctrl.s_db = sm83_ctrl_pkg::MEM;
                ctrl.t_db = sm83_ctrl_pkg::W;
                ctrl.wr_pc = 1'b1;
            end

            {sm83_isa_pkg::OP_LD_RR_NN, 3'd2}: begin
                done = 1'b1;
                ctrl.s_rr_wb = sm83_ctrl_pkg::RR_WB_WZ;
                ctrl.t_rr_wb = rr;
            end

            {sm83_isa_pkg::OP_JP_NN, 3'd2}: begin
                ctrl.ab_zero = 1'b1;                     // Idle bus cycle at 0x0000
                ctrl.s_rr_wb = sm83_ctrl_pkg::RR_WB_WZ;
                ctrl.t_rr_wb = sm83_ctrl_pkg::PC;
            end

            {sm83_isa_pkg::OP_INCDEC_RR, 3'd0}: begin
                ctrl.s_ab = rr;
                ctrl.idu = ir[3] ? sm83_ctrl_pkg::IDU_DEC : sm83_ctrl_pkg::IDU_INC;
                ctrl.s_rr_wb = sm83_ctrl_pkg::RR_WB_IDU;
                ctrl.t_rr_wb = rr;
            end

            {sm83_isa_pkg::OP_INCDEC_R, 3'd0}: begin
                done = 1'b1;
                ctrl.s_db = r_dst;
                ctrl.t_db = r_dst;
                ctrl.s_r_wb = sm83_ctrl_pkg::R_WB_ALU;
                ctrl.s_acc = sm83_ctrl_pkg::ACC_DB;
                ctrl.s_arg = sm83_ctrl_pkg::ARG_ONE;
                ctrl.alu_op = ir[0] ? sm83_isa_pkg::ALU_SUB : sm83_isa_pkg::ALU_ADD;
            end

            {sm83_isa_pkg::OP_LD_HL_R, 3'd0}: begin
                ctrl.s_ab = sm83_ctrl_pkg::HL;
                ctrl.s_db = r_src;
                ctrl.t_db = sm83_ctrl_pkg::MEM;          // Only bus write in the set
            end

            // Z <- [HL]
            {sm83_isa_pkg::OP_LD_R_HL, 3'd0},
            {sm83_isa_pkg::OP_ALU_A_HL, 3'd0}: begin
                ctrl.s_ab = sm83_ctrl_pkg::HL;
                ctrl.s_db = sm83_ctrl_pkg::MEM;
                ctrl.t_db = sm83_ctrl_pkg::Z;
            end

            {sm83_isa_pkg::OP_LD_R_N, 3'd1},
            {sm83_isa_pkg::OP_LD_R_HL, 3'd1}: begin
                done = 1'b1;
                ctrl.s_db = sm83_ctrl_pkg::Z;
                ctrl.t_db = r_dst;
            end

            {sm83_isa_pkg::OP_LD_R_R, 3'd0}: begin
                done = 1'b1;
                ctrl.s_db = r_src;
                ctrl.t_db = r_dst;
            end

            {sm83_isa_pkg::OP_ALU_A_HL, 3'd1},
            {sm83_isa_pkg::OP_ALU_A_N, 3'd1},
            {sm83_isa_pkg::OP_ALU_A_R, 3'd0}: begin
                done = 1'b1;
                ctrl.s_db = (step == 3'd0) ? r_src : sm83_ctrl_pkg::Z;
                ctrl.t_db = sm83_ctrl_pkg::A;
                ctrl.s_r_wb = sm83_ctrl_pkg::R_WB_ALU;
            end

            // Plain fetch, also covers unlisted opcodes
            default:
                done = 1'b1;
        endcase

        if (done)
            ctrl.wr_pc = 1'b1;
        ctrl.alu_flags_only = (ctrl.s_r_wb == sm83_ctrl_pkg::R_WB_ALU) &&
                              (ctrl.alu_op == sm83_isa_pkg::ALU_CP);
    end

endmodule

// File: source/sm83_datapath.sv
`timescale 1ns/10ps

module sm83_datapath #(
    parameter logic [sm83_isa_pkg::ADDR_W-1:0] PC_INIT = 16'h0000,
    parameter logic [sm83_isa_pkg::ADDR_W-1:0] SP_INIT = 16'hFFFE
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ce,
    sm83_ctrl_if.dp                             ctrl,
    input  logic [sm83_isa_pkg::WORD_W-1:0]     d_in,
    output logic [sm83_isa_pkg::ADDR_W-1:0]     addr,
    output logic [sm83_isa_pkg::WORD_W-1:0]     d_out,
    output logic                                write,
    output logic [sm83_isa_pkg::WORD_W-1:0]     data_in_latched
);

    logic [7:0]  rf [sm83_ctrl_pkg::Z:sm83_ctrl_pkg::A];
    logic [3:0]  flags;   // Z N H C
    logic [7:0]  db;
    logic [7:0]  acc;
    logic [7:0]  arg;
    logic [7:0]  alu_res;
    logic [7:0]  r_wb;
    logic [15:0] ab;
    logic [15:0] idu_res;
    logic [15:0] rr_wb;
    logic        f_z;
    logic        f_n;
    logic        f_h;
    logic        f_c;

    always_comb begin
        case (ctrl.s_db)
            sm83_ctrl_pkg::MEM:  db = d_in;
            sm83_ctrl_pkg::NONE: db = 8'h00;
            default:             db = rf[ctrl.s_db];
        endcase

        case (ctrl.s_ab)
            sm83_ctrl_pkg::WZ: ab = {rf[sm83_ctrl_pkg::W], rf[sm83_ctrl_pkg::Z]};
            sm83_ctrl_pkg::BC: ab = {rf[sm83_ctrl_pkg::B], rf[sm83_ctrl_pkg::C]};
            sm83_ctrl_pkg::DE: ab = {rf[sm83_ctrl_pkg::D], rf[sm83_ctrl_pkg::E]};
            sm83_ctrl_pkg::HL: ab = {rf[sm83_ctrl_pkg::H], rf[sm83_ctrl_pkg::L]};
            sm83_ctrl_pkg::SP: ab = {rf[sm83_ctrl_pkg::SPH], rf[sm83_ctrl_pkg::SPL]};
            default:           ab = {rf[sm83_ctrl_pkg::PCH], rf[sm83_ctrl_pkg::PCL]};
        endcase
    end

    // IDU works on the selected pair, not on the forced-zero bus
    assign idu_res = (ctrl.idu == sm83_ctrl_pkg::IDU_DEC) ? ab - 16'd1 : ab + 16'd1;
    assign rr_wb = (ctrl.s_rr_wb == sm83_ctrl_pkg::RR_WB_WZ) ?
                   {rf[sm83_ctrl_pkg::W], rf[sm83_ctrl_pkg::Z]} : idu_res;

    assign acc = (ctrl.s_acc == sm83_ctrl_pkg::ACC_DB) ? db : rf[sm83_ctrl_pkg::A];
    assign arg = (ctrl.s_arg == sm83_ctrl_pkg::ARG_ONE) ? 8'd1 : db;
    assign r_wb = (ctrl.s_r_wb == sm83_ctrl_pkg::R_WB_ALU) ? alu_res : db;

    sm83_alu alu (
        .op     (ctrl.alu_op),
        .acc    (acc),
        .arg    (arg),
        .c_in   (flags[0]),
        .res    (alu_res),
        .flag_z (f_z),
        .flag_n (f_n),
        .flag_h (f_h),
        .flag_c (f_c)
    );

    // Bus outputs depend on state only, so a stall holds them
    assign addr = (!rst || ctrl.ab_zero) ? '0 : ab;
    assign write = rst && (ctrl.t_db == sm83_ctrl_pkg::MEM);
    assign d_out = db;
    assign data_in_latched = d_in;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = sm83_ctrl_pkg::Z; i <= sm83_ctrl_pkg::A; i++)
                rf[i] <= 8'h00;
            {rf[sm83_ctrl_pkg::SPH], rf[sm83_ctrl_pkg::SPL]} <= SP_INIT;
            {rf[sm83_ctrl_pkg::PCH], rf[sm83_ctrl_pkg::PCL]} <= PC_INIT;
            flags <= 4'h0;
        end else if (ce) begin
            if (ctrl.wr_pc)
                {rf[sm83_ctrl_pkg::PCH], rf[sm83_ctrl_pkg::PCL]} <= idu_res;
            if (ctrl.s_rr_wb != sm83_ctrl_pkg::RR_WB_NONE) begin
                case (ctrl.t_rr_wb)
                    sm83_ctrl_pkg::WZ: {rf[sm83_ctrl_pkg::W], rf[sm83_ctrl_pkg::Z]} <= rr_wb;
                    sm83_ctrl_pkg::BC: {rf[sm83_ctrl_pkg::B], rf[sm83_ctrl_pkg::C]} <= rr_wb;
                    sm83_ctrl_pkg::DE: {rf[sm83_ctrl_pkg::D], rf[sm83_ctrl_pkg::E]} <= rr_wb;
                    sm83_ctrl_pkg::HL: {rf[sm83_ctrl_pkg::H], rf[sm83_ctrl_pkg::L]} <= rr_wb;
                    sm83_ctrl_pkg::SP: {rf[sm83_ctrl_pkg::SPH], rf[sm83_ctrl_pkg::SPL]} <= rr_wb;
                    default:           {rf[sm83_ctrl_pkg::PCH], rf[sm83_ctrl_pkg::PCL]} <= rr_wb;
                endcase
            end
            if (ctrl.t_db != sm83_ctrl_pkg::NONE && ctrl.t_db != sm83_ctrl_pkg::MEM &&
                !(ctrl.t_db == sm83_ctrl_pkg::A && ctrl.alu_flags_only))
                rf[ctrl.t_db] <= r_wb;
            if (ctrl.s_r_wb == sm83_ctrl_pkg::R_WB_ALU)
                flags <= {f_z, f_n, f_h, f_c};
        end
    end

endmodule

// File: source/sm83_core.sv
`timescale 1ns/10ps

module sm83_core #(
    parameter logic [sm83_isa_pkg::ADDR_W-1:0] PC_INIT = 16'h0000,
    parameter logic [sm83_isa_pkg::ADDR_W-1:0] SP_INIT = 16'hFFFE
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ce,
    input  logic [sm83_isa_pkg::WORD_W-1:0]     d_in,
    output logic [sm83_isa_pkg::ADDR_W-1:0]     addr,
    output logic [sm83_isa_pkg::WORD_W-1:0]     d_out,
    output logic                                write
);

    sm83_isa_pkg::opcode_t                  ir;
    logic [sm83_ctrl_pkg::STEP_W-1:0]       step;
    logic                                   done;
    logic [sm83_isa_pkg::WORD_W-1:0]        data_in_latched;

    sm83_ctrl_if ctrl ();   // Control word for the current step

    sm83_sequencer seq (
        .clk             (clk),
        .rst             (rst),
        .ce              (ce),
        .done            (done),
        .data_in_latched (data_in_latched),
        .ir              (ir),
        .step            (step)
    );

    sm83_decoder dec (
        .ir   (ir),
        .step (step),
        .done (done),
        .ctrl (ctrl.dec)
    );

    sm83_datapath #(
        .PC_INIT (PC_INIT),
        .SP_INIT (SP_INIT)
    ) dp (
        .clk             (clk),
        .rst             (rst),
        .ce              (ce),
        .ctrl            (ctrl.dp),
        .d_in            (d_in),
        .addr            (addr),
        .d_out           (d_out),
        .write           (write),
        .data_in_latched (data_in_latched)
    );

endmodule

// File: sim/sm83_properties.sv
`timescale 1ns/10ps

module sm83_properties #(
    parameter logic [7:0] WINDOW_HI = 8'h80   // Data window 0x8000..0x80FF
) (
    input logic        clk,
    input logic        rst,
    input logic        ce,
    input logic [15:0] addr,
    input logic [7:0]  d_out,
    input logic        write
);

    no_write_in_reset: assert property (@(posedge clk) !rst |-> !write)
        else $error("write asserted while in reset");

    write_in_window: assert property (@(posedge clk) disable iff (!rst)
        write |-> (addr[15:8] == WINDOW_HI))
        else $error("write outside the data window at %h", addr);

    // A stalled edge keeps the whole bus
    bus_holds_on_stall: assert property (@(posedge clk) disable iff (!rst)
        !ce |=> ($stable(addr) && $stable(write) && $stable(d_out)))
        else $error("bus changed across a stalled cycle");

endmodule

bind sm83_core sm83_properties props (
    .clk   (clk),
    .rst   (rst),
    .ce    (ce),
    .addr  (addr),
    .d_out (d_out),
    .write (write)
);

// File: sim/sm83_tb.sv
`timescale 1ns/10ps

module sm83_tb;

    localparam int NUM_INSTR = 200;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES = RESET_CYCLES + NUM_INSTR * 4 * 2 + 200;
    localparam logic [15:0] PC_INIT = 16'h0000;
    localparam logic [15:0] SP_INIT = 16'hFFFE;
    localparam int T_FETCH = 0;
    localparam int T_STORE = 1;
    localparam int T_ALU = 2;
    localparam int T_INCDEC = 3;
    localparam int T_JUMP = 4;
    localparam int T_STALL = 5;

    logic        clk = 1'b0;
    logic        rst;
    logic        ce;
    logic [7:0]  d_in;
    logic [15:0] addr;
    logic [7:0]  d_out;
    logic        write;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    integer      seed = 32102;
    int          errors [0:5];
    string       names [0:5] = '{"fetch_seq", "store", "alu", "incdec", "jump", "stall"};

    // Reference model registers indexed by the opcode register field
    logic [7:0]  r [0:7];
    int          tag [0:7];   // Test that last shaped each register
    int          hl_tag;
    logic [15:0] pc;
    logic [15:0] sp;
    logic [7:0]  z;
    logic [7:0]  w;
    logic [7:0]  ir;
    logic [2:0]  step;
    logic        fz, fn, fh, fc;
    logic        after_jump;
    int          fetches = 0;
    logic        prev_valid;
    logic        prev_ce;
    logic [15:0] prev_addr;
    logic [7:0]  prev_dout;
    logic        prev_write;

    sm83_core #(
        .PC_INIT (PC_INIT),
        .SP_INIT (SP_INIT)
    ) UUT (
        .clk   (clk),
        .rst   (rst),
        .ce    (ce),
        .d_in  (d_in),
        .addr  (addr),
        .d_out (d_out),
        .write (write)
    );

    always #50 clk = ~clk;

    assign d_in = mem[addr];   // Combinational read

    always @(posedge clk) begin
        if (write)
            mem[addr] <= d_out;
    end

    task automatic report_mismatch(input int t, input string what,
                                   input logic [15:0] exp_v, input logic [15:0] act_v);
        errors[t]++;
        $display("ERR %s %s expected %h actual %h at %0t", names[t], what, exp_v, act_v, $time);
    endtask

    function automatic logic [15:0] pair(input logic [1:0] f);
        case (f)
            2'd0:    return {r[0], r[1]};
            2'd1:    return {r[2], r[3]};
            2'd2:    return {r[4], r[5]};
            default: return sp;
        endcase
    endfunction

    task automatic set_pair(input logic [1:0] f, input logic [15:0] v, input int t);
        case (f)
            2'd0: begin
                {r[0], r[1]} = v;
                tag[0] = t;
                tag[1] = t;
            end
            2'd1: begin
                {r[2], r[3]} = v;
                tag[2] = t;
                tag[3] = t;
            end
            2'd2: begin
                {r[4], r[5]} = v;
                hl_tag = t;
                tag[4] = t;
                tag[5] = t;
            end
            default: sp = v;
        endcase
    endtask

    // Subtraction adds the complement and ADC and SBC take the carry flag
    task automatic alu_exec(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
                            output logic [7:0] res);
        logic       sub;
        logic       cin;
        logic [7:0] bb;
        logic [8:0] sum;
        logic [4:0] lo;
        sub = (op == 3'd2) || (op == 3'd3) || (op == 3'd7);
        cin = (op == 3'd1 || op == 3'd3) ? fc : sub;
        bb = sub ? ~b : b;
        sum = {1'b0, a} + {1'b0, bb} + {8'b0, cin};
        lo = {1'b0, a[3:0]} + {1'b0, bb[3:0]} + {4'b0, cin};
        case (op)
            3'd4:    res = a & b;
            3'd5:    res = a ^ b;
            3'd6:    res = a | b;
            default: res = sum[7:0];
        endcase
        fn = (op >= 3'd4 && op <= 3'd6) ? 1'b0 : sub;
        fh = (op >= 3'd4 && op <= 3'd6) ? 1'b0 : lo[4];
        fc = (op >= 3'd4 && op <= 3'd6) ? 1'b0 : sum[8];
        fz = (res == 8'h00);
    endtask

    task automatic alu_to_a(input logic [2:0] op, input logic [7:0] b);
        logic [7:0] v;
        alu_exec(op, r[7], b, v);
        if (op != 3'd7)
            r[7] = v;   // CP keeps A
        tag[7] = T_ALU;
    endtask

    task automatic reset_model();
        for (int i = 0; i < 8; i++) begin
            r[i] = 8'h00;
            tag[i] = T_STORE;
        end
        hl_tag = T_STORE;
        pc = PC_INIT;
        sp = SP_INIT;
        z = 8'h00;
        w = 8'h00;
        ir = 8'h00;
        step = 3'd0;
        {fz, fn, fh, fc} = 4'h0;
        after_jump = 1'b0;
        fetches = 0;
        prev_valid = 1'b0;
    endtask

    // One bus cycle with state effects only on an enabled edge
    task automatic model_cycle();
        logic [15:0] ea;
        logic        ew;
        logic [7:0]  ed;
        logic        fetch;
        int          t;
        logic [2:0]  d;
        logic [2:0]  s;
        logic [7:0]  v;
        ea = pc;
        ew = 1'b0;
        ed = 8'h00;
        fetch = 1'b0;
        t = after_jump ? T_JUMP : T_FETCH;
        d = ir[5:3];
        s = ir[2:0];
        if (ir == 8'h76 || ir == 8'h34 || ir == 8'h35 || ir == 8'h36) begin
            fetch = 1'b1;
        end else if (ir[7:6] == 2'b00 && ir[3:0] == 4'b0001) begin   // LD rr,nn
            if (step == 3'd2) begin
                fetch = 1'b1;
                if (ce)
                    set_pair(ir[5:4], {w, z}, T_STORE);
            end else if (ce) begin
                if (step == 3'd0)
                    z = ref_mem[pc];
                else
                    w = ref_mem[pc];
                pc = pc + 16'd1;
            end
        end else if (ir[7:6] == 2'b00 && s == 3'd3) begin            // INC/DEC rr
            if (step == 3'd0) begin
                ea = pair(ir[5:4]);
                if (ce)
                    set_pair(ir[5:4], ir[3] ? ea - 16'd1 : ea + 16'd1, T_INCDEC);
            end else begin
                fetch = 1'b1;
            end
        end else if (ir[7:6] == 2'b00 && s[2:1] == 2'b10) begin      // INC/DEC r
            fetch = 1'b1;
            if (ce) begin
                alu_exec(ir[0] ? 3'd2 : 3'd0, r[d], 8'd1, v);
                r[d] = v;
                tag[d] = T_INCDEC;
            end
        end else if ((ir[7:6] == 2'b00 || ir[7:6] == 2'b11) && s == 3'd6) begin
            if (step == 3'd0) begin                                   // Immediate byte
                if (ce) begin
                    z = ref_mem[pc];
                    pc = pc + 16'd1;
                end
            end else begin
                fetch = 1'b1;
                if (ce && ir[7:6] == 2'b00) begin
                    r[d] = z;
                    tag[d] = T_STORE;
                end else if (ce) begin
                    alu_to_a(d, z);
                end
            end
        end else if (ir[7] == 1'b0 && ir[6] == 1'b1 && d == 3'd6) begin // LD (HL),r
            if (step == 3'd0) begin
                ea = {r[4], r[5]};
                ew = 1'b1;
                ed = r[s];
                t = (tag[s] == T_STORE) ? hl_tag : tag[s];
                if (ce)
                    ref_mem[ea] = r[s];
            end else begin
                fetch = 1'b1;
            end
        end else if (ir[7] == 1'b1 && ir[6] == 1'b0 || ir[7:6] == 2'b01) begin
            if (s == 3'd6 && step == 3'd0) begin                      // Read (HL)
                ea = {r[4], r[5]};
                if (hl_tag == T_INCDEC)
                    t = T_INCDEC;
                if (ce)
                    z = ref_mem[ea];
            end else begin
                fetch = 1'b1;
                v = (s == 3'd6) ? z : r[s];
                if (ce && ir[7]) begin
                    alu_to_a(d, v);
                end else if (ce) begin
                    r[d] = v;
                    tag[d] = (s == 3'd6) ? T_STORE : tag[s];
                end
            end
        end else if (ir == 8'hC3) begin                               // JP nn
            if (step == 3'd2) begin
                ea = 16'h0000;
                t = T_JUMP;
                if (ce) begin
                    pc = {w, z};
                    after_jump = 1'b1;
                end
            end else if (step == 3'd3) begin
                fetch = 1'b1;
            end else if (ce) begin
                if (step == 3'd0)
                    z = ref_mem[pc];
                else
                    w = ref_mem[pc];
                pc = pc + 16'd1;
            end
        end else begin
            fetch = 1'b1;
        end

        if (!ce)
            t = T_STALL;
        if (addr !== ea)
            report_mismatch(t, "addr", ea, addr);
        if (write !== ew)
            report_mismatch(t, "write", {15'b0, ew}, {15'b0, write});
        if (ew && d_out !== ed)
            report_mismatch(t, "d_out", {8'b0, ed}, {8'b0, d_out});

        if (ce && fetch) begin
            ir = ref_mem[pc];
            pc = pc + 16'd1;
            step = 3'd0;
            fetches++;
            after_jump = 1'b0;
        end else if (ce) begin
            step = step + 3'd1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            reset_model();
            if (addr !== 16'h0000)
                report_mismatch(T_FETCH, "addr in reset", 16'h0000, addr);
            if (write !== 1'b0)
                report_mismatch(T_FETCH, "write in reset", 16'h0000, {15'b0, write});
        end else if (fetches <= NUM_INSTR) begin
            if (prev_valid && !prev_ce) begin
                if (addr !== prev_addr)
                    report_mismatch(T_STALL, "addr hold", prev_addr, addr);
                if (write !== prev_write)
                    report_mismatch(T_STALL, "write hold", {15'b0, prev_write}, {15'b0, write});
                if (d_out !== prev_dout)
                    report_mismatch(T_STALL, "d_out hold", {8'b0, prev_dout}, {8'b0, d_out});
            end
            prev_valid = 1'b1;
            prev_ce = ce;
            prev_addr = addr;
            prev_write = write;
            prev_dout = d_out;
            model_cycle();
        end
    end

    function automatic logic [2:0] pick_dst();
        int k;
        k = {$random(seed)} % 5;
        return (k == 4) ? 3'd7 : 3'(k);   // B C D E or A so that HL stays in the data window
    endfunction

    function automatic logic [2:0] pick_src();
        logic [2:0] s;
        s = 3'({$random(seed)} % 7);
        return (s == 3'd6) ? 3'd7 : s;
    endfunction

    task automatic gen_program();
        logic [7:0]  prog [$];
        logic [15:0] hl;
        logic [15:0] nn;
        logic [1:0]  rr;
        logic [2:0]  op;
        logic        dec;
        int          kind;
        int          k;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
            ref_mem[i] = mem[i];
        end
        hl = 16'h8000 | 16'($random(seed) & 8'hFF);
        prog.push_back(8'h21);
        prog.push_back(hl[7:0]);
        prog.push_back(hl[15:8]);
        for (int i = 1; i < NUM_INSTR; i++) begin
            kind = {$random(seed)} % 10;
            dec = 1'($random(seed));
            case (kind)
                0: prog.push_back(8'h00);
                1: begin
                    rr = 2'($random(seed));
                    nn = 16'($random(seed));
                    if (rr == 2'd2) begin
                        nn = {8'h80, nn[7:0]};
                        hl = nn;
                    end
                    prog.push_back({2'b00, rr, 4'b0001});
                    prog.push_back(nn[7:0]);
                    prog.push_back(nn[15:8]);
                end
                2: begin
                    rr = 2'($random(seed));
                    if (rr == 2'd2) begin
                        if (hl[7:0] == 8'hFF)
                            dec = 1'b1;
                        if (hl[7:0] == 8'h00)
                            dec = 1'b0;
                        hl = dec ? hl - 16'd1 : hl + 16'd1;
                    end
                    prog.push_back({2'b00, rr, dec, 3'b011});
                end
                3: prog.push_back({2'b00, pick_dst(), 2'b10, dec});
                4: begin
                    prog.push_back({2'b00, pick_dst(), 3'b110});
                    prog.push_back(8'($random(seed)));
                end
                5: prog.push_back({2'b01, pick_dst(), 3'($random(seed))});
                6, 7: begin
                    op = 3'($random(seed));
                    if (dec) begin
                        prog.push_back({2'b11, op, 3'b110});
                        prog.push_back(8'($random(seed)));
                    end else begin
                        prog.push_back({2'b10, op, 3'($random(seed))});
                    end
                    if (kind == 7)
                        prog.push_back(8'h77);   // Expose A right away
                end
                8: prog.push_back({5'b01110, pick_src()});
                default: begin
                    k = {$random(seed)} % 4;   // Skipped filler bytes
                    nn = PC_INIT + 16'(prog.size() + 3 + k);
                    prog.push_back(8'hC3);
                    prog.push_back(nn[7:0]);
                    prog.push_back(nn[15:8]);
                    for (int j = 0; j < k; j++)
                        prog.push_back(8'($random(seed)));
                end
            endcase
        end
        prog.push_back(8'h00);
        for (int j = 0; j < prog.size(); j++) begin
            mem[PC_INIT + 16'(j)] = prog[j];
            ref_mem[PC_INIT + 16'(j)] = prog[j];
        end
    endtask

    initial begin
        #(MAX_CYCLES * 100);
        $display("Timeout: the program did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b0;
        ce = 1'b1;
        for (int i = 0; i < 6; i++)
            errors[i] = 0;
        gen_program();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        while (fetches <= NUM_INSTR) begin
            @(posedge clk);
            ce <= ({$random(seed)} % 10) != 0;   // About one stall in ten
        end
        total = 0;
        for (int i = 0; i < 6; i++)
            total += errors[i];
        $display("Errors: fetch_seq=%0d store=%0d alu=%0d incdec=%0d jump=%0d stall=%0d",
                 errors[0], errors[1], errors[2], errors[3], errors[4], errors[5]);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
source/sm83_isa_pkg.sv
source/sm83_ctrl_pkg.sv
source/sm83_ctrl_if.sv
source/sm83_alu.sv
source/sm83_sequencer.sv
source/sm83_decoder.sv
source/sm83_datapath.sv
source/sm83_core.sv
sim/sm83_properties.sv
sim/sm83_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sm83_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
